// ==== source/opc5ls_consts.svh ====
`ifndef OPC5LS_CONSTS_SVH
`define OPC5LS_CONSTS_SVH

// data and address bus width
`define OPC5LS_WORD_W 16

// register select width, r0 to r15
`define OPC5LS_REG_SEL_W 4

// r0 always reads as zero
`define OPC5LS_REG_ZERO 4'd0

// r15 is the program counter
`define OPC5LS_REG_PC 4'd15

// first fetch address after reset
`define OPC5LS_RESET_VECTOR 16'h0000

`endif

// ==== source/opc5ls_pkg.sv ====
`include "opc5ls_consts.svh"

package opc5ls_pkg;

   typedef enum logic [2:0] {
      fetch0 = 3'h0,
      fetch1 = 3'h1,
      ea_ed  = 3'h2,
      rdmem  = 3'h3,
      exec   = 3'h4,
      wrmem  = 3'h5
   } opc5ls_state_e;

   typedef enum logic [3:0] {
      op_mov  = 4'h0,
      op_and  = 4'h1,
      op_or   = 4'h2,
      op_xor  = 4'h3,
      op_add  = 4'h4,
      op_adc  = 4'h5,
      op_sto  = 4'h6,
      op_ld   = 4'h7,
      op_ror  = 4'h8,
      op_not  = 4'h9,
      op_sub  = 4'hA,
      op_sbc  = 4'hB,
      op_cmp  = 4'hC,
      op_cmpc = 4'hD,
      op_bswp = 4'hE,
      op_int  = 4'hF
   } opc5ls_opcode_e;

   // predicate bits sit at the top of the word
   typedef struct packed {
      logic                           pred_c;
      logic                           pred_z;
      logic                           pinvert;
      logic                           len;
      opc5ls_opcode_e                 opcode;
      logic [`OPC5LS_REG_SEL_W-1:0]   src;
      logic [`OPC5LS_REG_SEL_W-1:0]   dst;
   } opc5ls_instr_t;

   // same bus word seen as instruction fields or as data
   typedef union packed {
      opc5ls_instr_t                  instr;
      logic [`OPC5LS_WORD_W-1:0]      raw;
   } opc5ls_word_u;

endpackage

// ==== source/opc5ls_ctrl_if.sv ====
`timescale 1ns/100ps

`include "opc5ls_consts.svh"

interface opc5ls_ctrl_if import opc5ls_pkg::*; ();

   // decided by control
   opc5ls_state_e                  state;
   opc5ls_instr_t                  ir;
   logic                           ir_rdmem;
   logic                           ir_wrmem;
   logic                           skip_eaed;
   logic                           reg_wr;

   // returned by the datapath
   logic                           carry_q;
   logic                           zero;
   logic [`OPC5LS_REG_SEL_W-1:0]   src_adr;

   modport ctrl (
      output state,
      output ir,
      output ir_rdmem,
      output ir_wrmem,
      output skip_eaed,
      output reg_wr,
      input  carry_q,
      input  zero,
      input  src_adr
   );

   modport dp (
      input  state,
      input  ir,
      input  ir_rdmem,
      input  ir_wrmem,
      input  skip_eaed,
      input  reg_wr,
      output carry_q,
      output zero,
      output src_adr
   );

endinterface

// ==== source/opc5ls_control.sv ====
`timescale 1ns/100ps

`include "opc5ls_consts.svh"

module opc5ls_control import opc5ls_pkg::*; (
   input  logic          clk,
   input  logic          reset_b,
   input  opc5ls_word_u  datain,
   opc5ls_ctrl_if.ctrl   ctl
);

   opc5ls_instr_t  din_instr;
   opc5ls_state_e  state_nxt;
   logic           pred_din;
   logic           pred_ir;
   logic           jump;

   function automatic logic pred_true(
      input opc5ls_instr_t  i,
      input logic           c,
      input logic           z
   );
      return i.pinvert ^ ((i.pred_c | c) & (i.pred_z | z));
   endfunction

   assign din_instr = datain.instr;

   // datain view before ir is loaded, ir view afterwards
   assign pred_din = pred_true(din_instr, ctl.carry_q, ctl.zero);
   assign pred_ir  = pred_true(ctl.ir, ctl.carry_q, ctl.zero);

   // r0 source with no memory access needs no address add
   assign ctl.skip_eaed = !((ctl.src_adr != `OPC5LS_REG_ZERO) || ctl.ir_rdmem || ctl.ir_wrmem);

   // compares and int only touch the flags
   assign ctl.reg_wr = (ctl.state == exec) &&
                       (ctl.ir.opcode != op_cmp) &&
                       (ctl.ir.opcode != op_cmpc) &&
                       (ctl.ir.opcode != op_int);

   assign jump = ctl.reg_wr && (ctl.ir.dst == `OPC5LS_REG_PC);

   always_comb
   begin
      case (ctl.state)
         fetch0 :
            state_nxt = din_instr.len ? fetch1 : (!pred_din ? fetch0 : ea_ed);
         fetch1 :
            state_nxt = !pred_ir ? fetch0 : (ctl.skip_eaed ? exec : ea_ed);
         ea_ed :
            state_nxt = !pred_ir      ? fetch0 :
                        ctl.ir_rdmem  ? rdmem  :
                        ctl.ir_wrmem  ? wrmem  : exec;
         rdmem :
            state_nxt = exec;
         // exec already sees the next instruction word unless it jumps
         exec :
            state_nxt = jump ? fetch0 : (din_instr.len ? fetch1 : ea_ed);
         default :
            state_nxt = fetch0;
      endcase
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         ctl.state    <= fetch0;
         ctl.ir       <= '0;
         ctl.ir_rdmem <= 1'b0;
         ctl.ir_wrmem <= 1'b0;
      end
      else
      begin
         ctl.state <= state_nxt;
         if ((ctl.state == fetch0) || (ctl.state == exec))
         begin
            ctl.ir       <= din_instr;
            ctl.ir_rdmem <= (din_instr.opcode == op_ld);
            ctl.ir_wrmem <= (din_instr.opcode == op_sto);
         end
      end
   end

   a_state_legal : assert property (@(posedge clk) disable iff (!reset_b)
      !$isunknown(ctl.state) && (ctl.state inside {fetch0, fetch1, ea_ed, rdmem, exec, wrmem}));

   // a store takes one bus cycle, then fetching resumes
   a_wrmem_then_fetch : assert property (@(posedge clk) disable iff (!reset_b)
      (ctl.state == wrmem) |=> (ctl.state == fetch0));

   a_rdmem_only_ld : assert property (@(posedge clk) disable iff (!reset_b)
      (ctl.state == rdmem) |-> ((ctl.ir.opcode == op_ld) && ($past(ctl.state) == ea_ed)));

endmodule

// ==== source/opc5ls_regfile.sv ====
`timescale 1ns/100ps

`include "opc5ls_consts.svh"

module opc5ls_regfile import opc5ls_pkg::*; (
   input  logic                        clk,
   input  logic                        reset_b,
   opc5ls_ctrl_if.dp                   ctl,
   input  logic [`OPC5LS_WORD_W-1:0]   result,
   output logic [`OPC5LS_WORD_W-1:0]   src_data,
   output logic [`OPC5LS_WORD_W-1:0]   pc
);

   // r0 to r14, r15 lives in pc
   logic [`OPC5LS_WORD_W-1:0]  gpr [0:14];
   logic                       pc_wr;

   assign pc_wr = ctl.reg_wr && (ctl.src_adr == `OPC5LS_REG_PC);

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         pc <= `OPC5LS_RESET_VECTOR;
      end
      else
      begin
         case (ctl.state)
            fetch0, fetch1 :
               pc <= pc + 1'b1;
            exec :
               pc <= pc_wr ? result : pc + 1'b1;
            default :
               pc <= pc;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (ctl.reg_wr && (ctl.src_adr != `OPC5LS_REG_PC))
      begin
         gpr[ctl.src_adr] <= result;
      end
   end

   // r0 is masked on read
   assign src_data = (ctl.src_adr == `OPC5LS_REG_PC)   ? pc :
                     (ctl.src_adr == `OPC5LS_REG_ZERO) ? '0 : gpr[ctl.src_adr];

   // memory cycles use the operand as address, pc must hold
   a_pc_hold : assert property (@(posedge clk) disable iff (!reset_b)
      ((ctl.state == rdmem) || (ctl.state == wrmem)) |=> $stable(pc));

endmodule

// ==== source/opc5ls_alu.sv ====
`timescale 1ns/100ps

`include "opc5ls_consts.svh"

module opc5ls_alu import opc5ls_pkg::*; (
   input  logic                        clk,
   input  logic                        reset_b,
   opc5ls_ctrl_if.dp                   ctl,
   input  logic [`OPC5LS_WORD_W-1:0]   src_data,
   input  logic [`OPC5LS_WORD_W-1:0]   operand,
   output logic [`OPC5LS_WORD_W-1:0]   result
);

   logic [`OPC5LS_WORD_W:0]    add_sum;
   logic [`OPC5LS_WORD_W:0]    sub_sum;
   logic                       add_cin;
   logic                       sub_cin;
   logic                       carry;
   logic [`OPC5LS_WORD_W-1:0]  result_q;

   assign add_cin = (ctl.ir.opcode == op_adc) && ctl.carry_q;

   // carry set means no borrow
   assign sub_cin = ((ctl.ir.opcode == op_sbc) || (ctl.ir.opcode == op_cmpc)) ?
                    ctl.carry_q : 1'b1;

   assign add_sum = {1'b0, src_data} + {1'b0, operand} + {{`OPC5LS_WORD_W{1'b0}}, add_cin};
   assign sub_sum = {1'b0, src_data} + {1'b0, ~operand} + {{`OPC5LS_WORD_W{1'b0}}, sub_cin};

   always_comb
   begin
      carry  = ctl.carry_q;
      result = operand;
      case (ctl.ir.opcode)
         op_and :
            result = src_data & operand;
         op_or :
            result = src_data | operand;
         op_xor :
            result = src_data ^ operand;
         op_add, op_adc :
            {carry, result} = add_sum;
         op_sub, op_sbc, op_cmp, op_cmpc :
            {carry, result} = sub_sum;
         // rotate right through carry
         op_ror :
            {result, carry} = {ctl.carry_q, operand};
         op_not :
            result = ~operand;
         op_bswp :
            result = {operand[7:0], operand[15:8]};
         // mov, ld and int pass the operand
         default :
            result = operand;
      endcase
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         ctl.carry_q <= 1'b0;
         result_q    <= '0;
      end
      else if (ctl.state == exec)
      begin
         ctl.carry_q <= carry;
         result_q    <= result;
      end
   end

   assign ctl.zero = (result_q == '0);

endmodule

// ==== source/opc5ls_operand.sv ====
`timescale 1ns/100ps

`include "opc5ls_consts.svh"

module opc5ls_operand import opc5ls_pkg::*; (
   input  logic                        clk,
   opc5ls_ctrl_if.dp                   ctl,
   input  opc5ls_word_u                datain,
   input  logic [`OPC5LS_WORD_W-1:0]   src_data,
   output logic [`OPC5LS_WORD_W-1:0]   operand
);

   always_ff @(posedge clk)
   begin
      case (ctl.state)
         // new instruction word, point at its source
         fetch0, exec :
         begin
            ctl.src_adr <= datain.instr.src;
            operand     <= '0;
         end
         fetch1 :
         begin
            ctl.src_adr <= ctl.skip_eaed ? ctl.ir.dst : ctl.ir.src;
            operand     <= datain.raw;
         end
         // effective address, then destination for exec or store data
         ea_ed :
         begin
            ctl.src_adr <= ctl.ir.dst;
            operand     <= src_data + operand;
         end
         rdmem :
         begin
            ctl.src_adr <= ctl.ir.dst;
            operand     <= datain.raw;
         end
         default :
         begin
            ctl.src_adr <= ctl.src_adr;
            operand     <= operand;
         end
      endcase
   end

endmodule

// ==== source/opc5ls_cpu.sv ====
`timescale 1ns/100ps

`include "opc5ls_consts.svh"

module opc5ls_cpu import opc5ls_pkg::*; (
   input  logic                        clk,
   input  logic                        reset_b,
   input  logic [`OPC5LS_WORD_W-1:0]   datain,
   output logic [`OPC5LS_WORD_W-1:0]   dataout,
   output logic [`OPC5LS_WORD_W-1:0]   address,
   output logic                        rnw
);

   opc5ls_word_u               din_w;
   logic [`OPC5LS_WORD_W-1:0]  src_data;
   logic [`OPC5LS_WORD_W-1:0]  operand;
   logic [`OPC5LS_WORD_W-1:0]  result;
   logic [`OPC5LS_WORD_W-1:0]  pc;

   opc5ls_ctrl_if ctl ();

   assign din_w = datain;

   opc5ls_control control0 (
      .clk      (clk),
      .reset_b  (reset_b),
      .datain   (din_w),
      .ctl      (ctl.ctrl)
   );

   opc5ls_regfile regfile0 (
      .clk      (clk),
      .reset_b  (reset_b),
      .ctl      (ctl.dp),
      .result   (result),
      .src_data (src_data),
      .pc       (pc)
   );

   opc5ls_alu alu0 (
      .clk      (clk),
      .reset_b  (reset_b),
      .ctl      (ctl.dp),
      .src_data (src_data),
      .operand  (operand),
      .result   (result)
   );

   opc5ls_operand operand0 (
      .clk      (clk),
      .ctl      (ctl.dp),
      .datain   (din_w),
      .src_data (src_data),
      .operand  (operand)
   );

   // data cycles drive the effective address, all others fetch at pc
   assign address = ((ctl.state == rdmem) || (ctl.state == wrmem)) ? operand : pc;
   assign dataout = src_data;
   assign rnw     = (ctl.state != wrmem);

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
   input  logic  rst_req,
   output logic  clk,
   output logic  reset_b
);

   // reset cycles still to go
   logic [2:0]  cnt;

   initial
   begin
      clk = 1'b0;
      cnt = 3'd5;
   end

   always #4 clk = ~clk;

   always @(negedge clk)
   begin
      if (rst_req)
         cnt <= 3'd5;
      else if (cnt != 3'd0)
         cnt <= cnt - 3'd1;
   end

   assign reset_b = (cnt == 3'd0) && !rst_req;

endmodule

// ==== bench/opc5ls_tb.sv ====
`timescale 1ns/100ps

`include "opc5ls_consts.svh"

module opc5ls_tb;

   logic         clk;
   logic         reset_b;
   logic         rst_req;
   logic         rnw;
   logic [15:0]  datain;
   logic [15:0]  dataout;
   logic [15:0]  address;
   logic [15:0]  mem [0:65535];
   logic [15:0]  mmem [0:65535];
   logic [15:0]  mr [0:15];
   logic [31:0]  seed;
   logic [31:0]  dut_q [$];
   logic [31:0]  exp_q [$];
   logic [15:0]  halt_adr;
   logic [15:0]  gp;
   int           halt_hits;
   int           errors;
   int           fails;

   tb_clock clock0 (
      .rst_req  (rst_req),
      .clk      (clk),
      .reset_b  (reset_b)
   );

   opc5ls_cpu dut0 (
      .clk      (clk),
      .reset_b  (reset_b),
      .datain   (datain),
      .dataout  (dataout),
      .address  (address),
      .rnw      (rnw)
   );

   assign datain = mem[address];

   // bus writes and halt loop detection, sampled mid cycle
   always @(negedge clk)
   begin
      if (reset_b && !rnw)
      begin
         dut_q.push_back({address, dataout});
         mem[address] = dataout;
      end
      if (reset_b && (address == halt_adr))
         halt_hits++;
   end

   function automatic logic [15:0] rand16();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed[31:16];
   endfunction

   function automatic logic [15:0] reg_value(input logic [3:0] n, input logic [15:0] pc);
      if (n == 4'h0)
         return 16'h0;
      else if (n == 4'hF)
         return pc;
      return mr[n];
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic note_timeout(input string why);
      $display("%s at %0t", why, $time);
      errors++;
   endtask

   task automatic emit(input logic [15:0] w);
      mem[gp]  = w;
      mmem[gp] = w;
      gp       = gp + 16'h1;
   endtask

   task automatic fill_memory();
      for (int a = 0; a < 65536; a++)
      begin
         mem[a]  = a[15:0] ^ {a[7:0], a[15:8]} ^ 16'h5a3c;
         mmem[a] = mem[a];
      end
   endtask

   // 0 alu, 1 predicates, 2 memory, 3 register rules, 4 mixed
   task automatic gen_program(input int mode);
      logic [15:0]  r;
      logic [15:0]  imm;
      logic [15:0]  j;
      logic [15:0]  patch_at;
      logic [2:0]   pr;
      logic [3:0]   op;
      logic [3:0]   src;
      logic [3:0]   dst;
      int           count;
      int           skip;
      fill_memory();
      gp = `OPC5LS_RESET_VECTOR;
      skip = 0;
      patch_at = 16'h0;
      // r13 and r14 are data base pointers
      for (int n = 1; n < 15; n++)
      begin
         emit({12'hD00, n[3:0]});
         r = rand16();
         emit((n >= 13) ? (16'h8000 | (r & 16'h00ff)) : r);
      end
      count = 8 + (rand16() % 24);
      for (int i = 0; i < count; i++)
      begin
         r   = rand16();
         imm = rand16();
         j   = rand16();
         pr  = ((mode == 0) || (mode == 2)) ? 3'b110 : r[15:13];
         op  = r[11:8];
         src = r[7:4];
         dst = r[3:0] % 4'd13;
         if ((mode == 3) && imm[15])
            src = 4'h0;
         if ((mode == 2) && imm[13])
            op = imm[14] ? 4'h6 : 4'h7;
         if (((op == 4'h6) || (op == 4'h7)) && (mode != 2) && (mode != 4))
            op = op ^ 4'h4;
         else if ((op == 4'h6) || (op == 4'h7))
         begin
            src = imm[12] ? 4'hE : 4'hD;
            imm = imm & 16'h00ff;
            if (op == 4'h6)
               dst = r[3:0];
         end
         if (((mode == 3) || (mode == 4)) && (skip == 0) && (j[2:0] == 3'h0))
         begin
            // forward jump, target patched later
            emit({pr, 1'b1, 4'h0, 4'h0, 4'hF});
            patch_at = gp;
            emit(16'h0);
            skip = 1 + j[4:3];
         end
         else
         begin
            emit({pr, r[12], op, src, dst});
            if (r[12])
               emit(imm);
            if (skip > 0)
            begin
               skip--;
               if (skip == 0)
               begin
                  mem[patch_at]  = gp;
                  mmem[patch_at] = gp;
               end
            end
         end
      end
      if (skip != 0)
      begin
         mem[patch_at]  = gp;
         mmem[patch_at] = gp;
      end
      // adc r1 catches the final carry
      emit(16'hC501);
      for (int n = 0; n < 16; n++)
      begin
         emit({12'hD60, n[3:0]});
         emit({12'hF00, n[3:0]});
      end
      halt_adr = gp;
      emit(16'hD00F);
      emit(halt_adr);
   endtask

   // instruction set interpreter on its own memory copy
   task automatic run_model();
      logic [15:0]  pc;
      logic [15:0]  w;
      logic [15:0]  imm;
      logic [15:0]  rs;
      logic [15:0]  rd;
      logic [15:0]  ea;
      logic [15:0]  opd;
      logic [15:0]  res;
      logic [16:0]  diff;
      logic [3:0]   op;
      logic         c;
      logic         z;
      logic         cr;
      logic         bin;
      int           steps;
      pc = `OPC5LS_RESET_VECTOR;
      c = 1'b0;
      z = 1'b1;
      steps = 0;
      for (int i = 0; i < 16; i++)
         mr[i] = 16'h0;
      while ((pc != halt_adr) && (steps < 10000))
      begin
         steps++;
         w = mmem[pc];
         pc = pc + 16'h1;
         imm = 16'h0;
         if (w[12])
         begin
            imm = mmem[pc];
            pc = pc + 16'h1;
         end
         op = w[11:8];
         if (w[13] ^ ((w[15] | c) & (w[14] | z)))
         begin
            rs = reg_value(w[7:4], pc);
            rd = reg_value(w[3:0], pc);
            ea = rs + imm;
            if (op == 4'h6)
            begin
               mmem[ea] = rd;
               exp_q.push_back({ea, rd});
            end
            else
            begin
               opd = (op == 4'h7) ? mmem[ea] : ea;
               cr  = c;
               res = opd;
               case (op)
                  4'h1 : res = rd & opd;
                  4'h2 : res = rd | opd;
                  4'h3 : res = rd ^ opd;
                  4'h4, 4'h5 :
                     {cr, res} = {1'b0, rd} + {1'b0, opd} + {16'h0, (op == 4'h5) && c};
                  4'hA, 4'hB, 4'hC, 4'hD :
                  begin
                     // borrow in only for sbc and cmpc with carry clear
                     bin  = ((op == 4'hB) || (op == 4'hD)) && !c;
                     diff = {1'b0, rd} - {1'b0, opd} - {16'h0, bin};
                     res  = diff[15:0];
                     cr   = !diff[16];
                  end
                  4'h8 :
                  begin
                     res = {c, opd[15:1]};
                     cr  = opd[0];
                  end
                  4'h9 : res = ~opd;
                  4'hE : res = {opd[7:0], opd[15:8]};
                  default : res = opd;
               endcase
               c = cr;
               z = (res == 16'h0);
               if ((op != 4'hC) && (op != 4'hD) && (op != 4'hF))
               begin
                  if (w[3:0] == 4'hF)
                     pc = res;
                  else if (w[3:0] != 4'h0)
                     mr[w[3:0]] = res;
               end
            end
         end
      end
   endtask

   task automatic run_test(input int mode);
      int n;
      rst_req <= 1'b1;
      @(negedge clk);
      gen_program(mode);
      dut_q.delete();
      exp_q.delete();
      halt_hits = 0;
      run_model();
      rst_req <= 1'b0;
      n = 0;
      while (!reset_b && (n < 20))
      begin
         @(negedge clk);
         n++;
      end
      if (!reset_b)
      begin
         note_timeout("reset was never released");
         return;
      end
      n = 0;
      while ((halt_hits < 4) && (n < 20000))
      begin
         @(negedge clk);
         n++;
      end
      if (halt_hits < 4)
      begin
         note_timeout("program never reached its halt loop");
         return;
      end
      check("store count", dut_q.size(), exp_q.size());
      for (int i = 0; (i < exp_q.size()) && (i < dut_q.size()); i++)
         check($sformatf("store %0d", i), dut_q[i], exp_q[i]);
   endtask

   task automatic reset_test();
      int n;
      int e0;
      e0 = errors;
      rst_req <= 1'b1;
      @(negedge clk);
      rst_req <= 1'b0;
      for (int i = 0; i < 3; i++)
      begin
         @(negedge clk);
         check("rnw in reset", rnw, 1'b1);
         check("address in reset", address, `OPC5LS_RESET_VECTOR);
      end
      n = 0;
      while (!reset_b && (n < 200))
      begin
         #1;
         n++;
      end
      if (!reset_b)
         note_timeout("reset was never released");
      check("rnw at release", rnw, 1'b1);
      check("address at release", address, `OPC5LS_RESET_VECTOR);
      @(negedge clk);
      // one fetch0 has passed
      check("rnw after release", rnw, 1'b1);
      check("address after release", address, `OPC5LS_RESET_VECTOR + 16'h1);
      if (errors != e0)
         fails++;
      $display("test reset: %0d errors", errors - e0);
   endtask

   task automatic run_group(input string name, input int mode, input int progs);
      int e0;
      e0 = errors;
      for (int i = 0; i < progs; i++)
         run_test(mode);
      if (errors != e0)
         fails++;
      $display("test %s: %0d programs, %0d errors", name, progs, errors - e0);
   endtask

   initial
   begin
      seed = 32'h322b;
      errors = 0;
      fails = 0;
      rst_req = 1'b0;
      halt_adr = 16'hffff;
      halt_hits = 0;
      gp = 16'h0;
      fill_memory();
      reset_test();
      run_group("alu", 0, 20);
      run_group("predication", 1, 20);
      run_group("memory", 2, 20);
      run_group("registers", 3, 20);
      run_group("random", 4, 200);
      $display("tests 6, failed %0d, errors %0d", fails, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== project.f ====
+incdir+source
source/opc5ls_pkg.sv
source/opc5ls_ctrl_if.sv
source/opc5ls_control.sv
source/opc5ls_regfile.sv
source/opc5ls_alu.sv
source/opc5ls_operand.sv
source/opc5ls_cpu.sv
bench/tb_clock.sv
bench/opc5ls_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= opc5ls_tb
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(filter-out +incdir+%,$(shell cat project.f))
HDRS := $(wildcard source/*.svh)
SIM  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) project.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f project.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(BUILD)
